// File: filelist.f
logic/core_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/core_top.sv
tests/core_assert.sv
tests/core_tb.sv

// File: run.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module core_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcore_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1

// File: tests/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int ROM_DEPTH  = 256;
    localparam int EXP_DEPTH  = 64;
    localparam int SKIP_OFF   = 12; // Jumps over the two wrong-path slots.

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_OR   = 3'b110;

    logic        clk;
    logic        arst_n;
    inst_t       inst;
    xlen_t       inst_addr;
    logic        retire_valid;
    reg_addr_t   retire_rd;
    xlen_t       retire_data;

    inst_t       rom [ROM_DEPTH];
    reg_addr_t   exp_rd [EXP_DEPTH];
    xlen_t       exp_data [EXP_DEPTH];
    xlen_t       arch_regs [32];
    xlen_t       arch_mem [DMEM_WORDS];
    int          rom_len;
    int          exp_len;
    int          errors;
    logic [31:0] lcg_state;
    logic        tables_ready;

    core_top i_core_top (
        .clk, .arst_n, .inst, .inst_addr, .retire_valid, .retire_rd, .retire_data
    );

    bind core_top core_assert i_core_assert (.*);

    // Instruction ROM, NOPs past the program.
    assign inst = (inst_addr[63:10] == '0) ? rom[inst_addr[9:2]] : NOP_INST;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic xlen_t sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic inst_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t b_type(input logic [12:0] off, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_t j_type(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic draw_imm(output logic [11:0] imm);
        lcg_state = lcg_next(lcg_state);
        imm = lcg_state[27:16];
        if (imm == '0) begin
            imm = 12'h001; // Keeps x1 nonzero for the BNE cases.
        end
    endtask

    task automatic put_inst(input inst_t word);
        rom[rom_len[7:0]] = word;
        rom_len++;
    endtask

    task automatic expect_write(input reg_addr_t rd, input xlen_t value);
        if (rd != '0) begin
            exp_rd[exp_len[5:0]]   = rd;
            exp_data[exp_len[5:0]] = value;
            exp_len++;
            arch_regs[rd] = value;
        end
    endtask

    task automatic wrong_path_pair();
        put_inst(i_type(12'h7ff, 5'd0, F3_ADD, 5'd20, OPC_OPIMM));
        put_inst(i_type(12'h555, 5'd0, F3_ADD, 5'd21, OPC_OPIMM));
    endtask

    task automatic addi_imm(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        put_inst(i_type(imm, rs1, F3_ADD, rd, OPC_OPIMM));
        expect_write(rd, arch_regs[rs1] + sext12(imm));
    endtask

    task automatic alu_rr(input logic [6:0] f7, input logic [2:0] f3, input reg_addr_t rd,
                          input reg_addr_t rs1, input reg_addr_t rs2);
        xlen_t a;
        xlen_t b;
        xlen_t y;
        a = arch_regs[rs1];
        b = arch_regs[rs2];
        case (f3)
            F3_AND:  y = a & b;
            F3_OR:   y = a | b;
            default: y = (f7 == F7_SUB) ? a - b : a + b;
        endcase
        put_inst(r_type(f7, rs2, rs1, f3, rd));
        expect_write(rd, y);
    endtask

    task automatic store_dw(input reg_addr_t rs2, input reg_addr_t rs1, input logic [11:0] imm);
        xlen_t addr;
        addr = arch_regs[rs1] + sext12(imm);
        arch_mem[addr[8:3]] = arch_regs[rs2];
        put_inst(s_type(imm, rs2, rs1));
    endtask

    task automatic load_dw(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        xlen_t addr;
        addr = arch_regs[rs1] + sext12(imm);
        put_inst(i_type(imm, rs1, 3'b011, rd, OPC_LOAD));
        expect_write(rd, arch_mem[addr[8:3]]);
    endtask

    task automatic branch_cmp(input logic ne, input reg_addr_t rs1, input reg_addr_t rs2);
        logic taken;
        taken = (arch_regs[rs1] == arch_regs[rs2]) != ne;
        put_inst(b_type(13'(SKIP_OFF), rs2, rs1, {2'b00, ne}));
        if (taken) begin
            wrong_path_pair();
        end
    endtask

    task automatic jump_link(input reg_addr_t rd);
        expect_write(rd, 64'(rom_len) * 64'd4 + 64'd4);
        put_inst(j_type(21'(SKIP_OFF), rd));
        wrong_path_pair();
    endtask

    task automatic build_program();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [11:0] imm_c;
        logic [11:0] imm_d;
        draw_imm(imm_a);
        draw_imm(imm_b);
        draw_imm(imm_c);
        draw_imm(imm_d);
        // Dependent ALU chain.
        addi_imm(5'd1, 5'd0, imm_a);
        addi_imm(5'd2, 5'd1, imm_b);
        alu_rr(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2);
        alu_rr(F7_SUB,  F3_ADD, 5'd4, 5'd3, 5'd1);
        alu_rr(F7_BASE, F3_AND, 5'd5, 5'd4, 5'd3);
        alu_rr(F7_BASE, F3_OR,  5'd6, 5'd5, 5'd2);
        addi_imm(5'd0, 5'd1, imm_c); // Sink into x0.
        alu_rr(F7_BASE, F3_ADD, 5'd7, 5'd0, 5'd1);
        // Stores and loads around base 64.
        addi_imm(5'd8, 5'd0, 12'd64);
        store_dw(5'd3, 5'd8, 12'd0);
        store_dw(5'd4, 5'd8, 12'd8);
        store_dw(5'd6, 5'd8, 12'd16);
        load_dw(5'd9, 5'd8, 12'd16); // Right behind its store.
        load_dw(5'd10, 5'd8, 12'd0);
        load_dw(5'd11, 5'd8, 12'd8);
        addi_imm(5'd14, 5'd0, imm_d);
        store_dw(5'd14, 5'd8, 12'hff8);
        load_dw(5'd15, 5'd8, 12'hff8);
        // Load-use on rs1, then on rs2.
        alu_rr(F7_BASE, F3_ADD, 5'd12, 5'd15, 5'd1);
        load_dw(5'd16, 5'd8, 12'd8);
        alu_rr(F7_SUB, F3_ADD, 5'd13, 5'd12, 5'd16);
        // Branches, taken and not taken.
        addi_imm(5'd17, 5'd1, 12'd0);
        branch_cmp(1'b0, 5'd17, 5'd1);
        branch_cmp(1'b1, 5'd1, 5'd0);
        branch_cmp(1'b0, 5'd1, 5'd0);
        branch_cmp(1'b1, 5'd7, 5'd1);
        load_dw(5'd18, 5'd8, 12'd0);
        branch_cmp(1'b0, 5'd18, 5'd10);
        // Jumps with and without a link.
        jump_link(5'd19);
        alu_rr(F7_BASE, F3_ADD, 5'd22, 5'd19, 5'd19);
        jump_link(5'd0);
        alu_rr(F7_BASE, F3_OR, 5'd24, 5'd0, 5'd0);
    endtask

    task automatic check_rd(input int idx, input reg_addr_t got, input reg_addr_t want);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: retirement %0d wrote x%0d, expected x%0d",
                     $time, idx, got, want);
        end
    endtask

    task automatic check_data(input int idx, input xlen_t got, input xlen_t want);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: retirement %0d returned %h, expected %h",
                     $time, idx, got, want);
        end
    endtask

    initial begin
        arst_n       = 1'b0;
        errors       = 0;
        rom_len      = 0;
        exp_len      = 0;
        lcg_state    = 32'd86540;
        tables_ready = 1'b0;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i[7:0]] = NOP_INST;
        end
        for (int i = 0; i < 32; i++) begin
            arch_regs[i[4:0]] = '0;
        end
        build_program();
        tables_ready = 1'b1;

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < exp_len; i++) begin
            @(negedge clk);
            while (!retire_valid) begin
                @(negedge clk);
            end
            check_rd(i, retire_rd, exp_rd[i[5:0]]);
            check_data(i, retire_data, exp_data[i[5:0]]);
        end

        // Nothing else may retire afterwards.
        repeat (10) begin
            @(negedge clk);
            if (retire_valid) begin
                errors++;
                $display("Unexpected retirement at %0t: x%0d was written after the last result",
                         $time, retire_rd);
            end
        end

        errors += i_core_top.i_core_assert.fail_count;
        $display("Finished with %0d errors over %0d expected retirements", errors, exp_len);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (tables_ready);
        #((exp_len * 20 + 50) * CLK_PERIOD);
        $display("Timeout: retirement stalled before all expected results arrived");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/core_assert.sv
`timescale 1ns/1ns
`default_nettype none

module core_assert import core_pkg::*; (
    input logic      clk,
    input logic      arst_n,
    input xlen_t     inst_addr,
    input logic      retire_valid,
    input reg_addr_t retire_rd
);

    int fail_count = 0;

    // Pipeline registers hold bubbles under reset.
    retire_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !retire_valid)
        else begin
            fail_count++;
            $error("retire_valid is high while reset is asserted");
        end

    retire_rd_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n) retire_valid |-> (retire_rd != '0))
        else begin
            fail_count++;
            $error("retire_valid is high with retire_rd equal to x0");
        end

    fetch_aligned: assert property (@(posedge clk) inst_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("inst_addr is not 4-byte aligned");
        end

endmodule

`default_nettype wire

// File: logic/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  inst_t     inst,
    output xlen_t     inst_addr,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output xlen_t     retire_data
);

    xlen_t      if_pc;
    inst_t      if_inst;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    logic       uses_rs1;
    logic       uses_rs2;
    id_ex_t     id_ex;
    ex_me_t     ex_me;
    me_wb_t     me_wb;
    logic       stall;
    logic       flush;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;
    logic       redirect;
    xlen_t      redirect_pc;

    fetch_stage i_fetch_stage (
        .clk, .arst_n, .stall, .flush, .redirect_pc, .inst,
        .pc(inst_addr), .if_pc, .if_inst
    );

    decode_stage i_decode_stage (
        .clk, .arst_n, .if_pc, .if_inst, .rs1_data, .rs2_data, .stall, .flush,
        .rs1_addr, .rs2_addr, .uses_rs1, .uses_rs2, .id_ex
    );

    register_file i_register_file (
        .clk, .arst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wr_en(me_wb.wr_en), .wr_addr(me_wb.rd), .wr_data(me_wb.wb_data)
    );

    hazard_unit i_hazard_unit (
        .rs1_addr, .rs2_addr, .uses_rs1, .uses_rs2, .id_ex, .ex_me, .me_wb,
        .redirect, .stall, .flush, .fwd_a, .fwd_b
    );

    execute_stage i_execute_stage (
        .clk, .arst_n, .id_ex, .fwd_a, .fwd_b,
        .me_fwd(ex_me.alu_res), .wb_fwd(me_wb.wb_data),
        .redirect, .redirect_pc, .ex_me
    );

    memory_stage i_memory_stage (.clk, .arst_n, .ex_me, .me_wb);

    // Retire straight from the WB register.
    assign retire_valid = me_wb.wr_en && (me_wb.rd != '0);
    assign retire_rd    = me_wb.rd;
    assign retire_data  = me_wb.wb_data;

endmodule

`default_nettype wire

// File: logic/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  ex_me_t ex_me,
    output me_wb_t me_wb
);

    xlen_t                         dmem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0] idx;
    xlen_t                         load_data;
    me_wb_t                        wb_d;

    assign idx = ex_me.alu_res[$clog2(DMEM_WORDS)+2:3]; // Doubleword address.

    always_ff @(posedge clk) begin
        if (ex_me.is_store) begin
            dmem[idx] <= ex_me.store_data;
        end
    end

    assign load_data = dmem[idx];

    always_comb begin
        wb_d.wb_data = (ex_me.is_load && !ex_me.link_pc_sel) ? load_data : ex_me.alu_res;
        wb_d.rd      = ex_me.rd;
        wb_d.wr_en   = ex_me.wr_en;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            me_wb <= '0;
        end else begin
            me_wb <= wb_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  id_ex_t     id_ex,
    input  logic [1:0] fwd_a,
    input  logic [1:0] fwd_b,
    input  xlen_t      me_fwd,
    input  xlen_t      wb_fwd,
    output logic       redirect,
    output xlen_t      redirect_pc,
    output ex_me_t     ex_me
);

    xlen_t  op_a;
    xlen_t  op_b_reg;
    xlen_t  op_b;
    xlen_t  alu_y;
    xlen_t  link_pc;
    logic   taken;
    ex_me_t ex_d;

    always_comb begin
        case (fwd_a)
            FWD_ME:  op_a = me_fwd;
            FWD_WB:  op_a = wb_fwd;
            default: op_a = id_ex.rs1_data;
        endcase
        case (fwd_b)
            FWD_ME:  op_b_reg = me_fwd;
            FWD_WB:  op_b_reg = wb_fwd;
            default: op_b_reg = id_ex.rs2_data;
        endcase
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : op_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            default: alu_y = op_a + op_b;
        endcase
    end

    // BEQ when branch_ne is low, BNE otherwise.
    assign taken       = id_ex.is_branch && ((op_a == op_b_reg) != id_ex.branch_ne);
    assign redirect    = taken || id_ex.is_jal;
    assign redirect_pc = id_ex.pc + id_ex.imm;
    assign link_pc     = id_ex.pc + 64'd4;

    always_comb begin
        ex_d.link_pc_sel = id_ex.is_jal;
        ex_d.alu_res     = ex_d.link_pc_sel ? link_pc : alu_y;
        ex_d.store_data  = op_b_reg;
        ex_d.rd          = id_ex.rd;
        ex_d.is_load     = id_ex.is_load;
        ex_d.is_store    = id_ex.is_store;
        ex_d.wr_en       = id_ex.wr_en;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_me <= '0;
        end else begin
            ex_me <= ex_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit import core_pkg::*; (
    input  reg_addr_t  rs1_addr,
    input  reg_addr_t  rs2_addr,
    input  logic       uses_rs1,
    input  logic       uses_rs2,
    input  id_ex_t     id_ex,
    input  ex_me_t     ex_me,
    input  me_wb_t     me_wb,
    input  logic       redirect,
    output logic       stall,
    output logic       flush,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b
);

    logic load_use;

    // Youngest producer wins.
    function automatic logic [1:0] fwd_sel(input reg_addr_t src);
        logic [1:0] sel;
        sel = FWD_NONE;
        if (src != '0) begin
            if (ex_me.wr_en && ex_me.rd == src) begin
                sel = FWD_ME;
            end else if (me_wb.wr_en && me_wb.rd == src) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    // Load in EX feeding the instruction in ID.
    assign load_use = id_ex.is_load && (id_ex.rd != '0) &&
                      ((uses_rs1 && rs1_addr == id_ex.rd) ||
                       (uses_rs2 && rs2_addr == id_ex.rd));

    assign flush = redirect;
    assign stall = load_use && !redirect; // Squashed anyway on a redirect.

    always_comb begin
        fwd_a = fwd_sel(id_ex.rs1_addr);
        fwd_b = fwd_sel(id_ex.rs2_addr);
    end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  xlen_t     wr_data
);

    xlen_t regs [0:31];
    logic  wr_live;

    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write shows through to the reader.
    assign rs1_data = (wr_live && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (wr_live && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  xlen_t     if_pc,
    input  inst_t     if_inst,
    input  xlen_t     rs1_data,
    input  xlen_t     rs2_data,
    input  logic      stall,
    input  logic      flush,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      uses_rs1,
    output logic      uses_rs2,
    output id_ex_t    id_ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_j;
    logic       legal;
    id_ex_t     dec;

    assign opcode   = if_inst[6:0];
    assign rd       = if_inst[11:7];
    assign funct3   = if_inst[14:12];
    assign funct7   = if_inst[31:25];
    assign rs1_addr = if_inst[19:15];
    assign rs2_addr = if_inst[24:20];

    assign imm_i = {{52{if_inst[31]}}, if_inst[31:20]};
    assign imm_s = {{52{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
    assign imm_b = {{51{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                    if_inst[11:8], 1'b0};
    assign imm_j = {{43{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
                    if_inst[30:21], 1'b0};

    always_comb begin
        dec      = '0;
        legal    = 1'b1;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        dec.alu_op = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                dec.wr_en = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: dec.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: dec.alu_op = ALU_OR;
                    default:              legal      = 1'b0;
                endcase
            end
            OPC_OPIMM, OPC_LOAD: begin
                legal       = (funct3 == (opcode == OPC_LOAD ? 3'b011 : 3'b000));
                uses_rs1    = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.is_load = (opcode == OPC_LOAD);
                dec.wr_en   = 1'b1;
            end
            OPC_STORE: begin
                legal        = (funct3 == 3'b011); // SD only.
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                dec.use_imm  = 1'b1;
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
            end
            OPC_BRANCH: begin
                legal         = (funct3 == 3'b000) || (funct3 == 3'b001);
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
            end
            OPC_JAL: begin
                dec.imm    = imm_j;
                dec.is_jal = 1'b1;
                dec.wr_en  = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        if (!legal) begin
            dec      = '0;
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
        end else begin
            dec.pc       = if_pc;
            dec.rs1_addr = uses_rs1 ? rs1_addr : '0;
            dec.rs2_addr = uses_rs2 ? rs2_addr : '0;
            dec.rs1_data = rs1_data;
            dec.rs2_data = rs2_data;
            dec.rd       = dec.wr_en ? rd : '0;
        end
    end

    // ID/EX register. All-zero is a bubble.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (stall || flush) begin
            id_ex <= '0;
        end else begin
            id_ex <= dec;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import core_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  stall,
    input  logic  flush,
    input  xlen_t redirect_pc,
    input  inst_t inst,
    output xlen_t pc,
    output xlen_t if_pc,
    output inst_t if_inst
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (flush) begin
            pc <= redirect_pc; // Branch or JAL taken in EX.
        end else if (!stall) begin
            pc <= pc + 64'd4;
        end
    end

    // IF/ID register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_pc   <= '0;
            if_inst <= NOP_INST;
        end else if (flush) begin
            if_pc   <= '0;
            if_inst <= NOP_INST;
        end else if (!stall) begin
            if_pc   <= pc;
            if_inst <= inst;
        end
    end

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;

    // Major opcodes of the supported subset.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Operand source for EX.
    localparam logic [1:0] FWD_NONE = 2'd0;
    localparam logic [1:0] FWD_ME   = 2'd1;
    localparam logic [1:0] FWD_WB   = 2'd2;

    localparam int    DMEM_WORDS = 64;
    localparam inst_t NOP_INST   = 32'h0000_0013; // addi x0, x0, 0

    typedef struct packed {
        xlen_t     pc;
        xlen_t     imm;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        reg_addr_t rd;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        logic      wr_en;
    } id_ex_t;

    typedef struct packed {
        xlen_t     alu_res;     // Holds pc+4 for JAL.
        xlen_t     store_data;
        reg_addr_t rd;
        logic      is_load;
        logic      is_store;
        logic      wr_en;
        logic      link_pc_sel;
    } ex_me_t;

    typedef struct packed {
        xlen_t     wb_data;
        reg_addr_t rd;
        logic      wr_en;
    } me_wb_t;

endpackage

`default_nettype wire
